//--- cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Bus widths
`define CPU_ADDR_W   16  // Address bus
`define CPU_DATA_W   8   // Data bus

// First fetch address after reset
`define CPU_RESET_PC 16'h0000

// Clocks per machine cycle, fixed
`define CPU_TCYCLES  4

`endif

//--- cpu_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

	// Bus words
	typedef logic [`CPU_ADDR_W-1:0] addr_t;
	typedef logic [`CPU_DATA_W-1:0] byte_t;

	// Register field as found in op[5:3] and op[2:0]
	typedef enum logic [2:0] {
		REG_B, REG_C, REG_D, REG_E,
		REG_H, REG_L, REG_MEM, REG_A  // REG_MEM is (HL) or immediate
	} reg_sel_t;

	// Low eight follow op[5:3] of the ALU block
	typedef enum logic [3:0] {
		ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
		ALU_AND, ALU_XOR, ALU_OR, ALU_CP,
		ALU_INC, ALU_DEC
	} alu_op_t;

	typedef struct packed {
		logic z;  // Zero
		logic n;  // Subtract
		logic h;  // Half carry
		logic c;  // Carry
	} flags_t;

	// Kind of machine cycle in progress
	typedef enum logic [2:0] {
		IFETCH, IMM_LO, IMM_HI, MEM_READ, MEM_WRITE, JUMP
	} mstate_t;

	typedef logic [1:0] tcycle_t;  // Clock within a machine cycle

endpackage

`default_nettype wire

//--- regfile_if.sv
`timescale 1ns/1ps
`default_nettype none

interface regfile_if import cpu_pkg::*; ();
	reg_sel_t   src_sel;     // Operand register
	byte_t      src_data;
	byte_t      ext_data;    // Byte returned for REG_MEM, immediate or (HL)
	reg_sel_t   dst_sel;     // Write target
	logic       dst_we;
	byte_t      dst_data;
	flags_t     flags;
	logic [3:0] flags_we;    // Per-flag mask, z n h c order
	flags_t     flags_next;
	byte_t      a;           // Accumulator, first ALU operand
	addr_t      hl;          // Pointer for indirect cycles

	// Storage side
	modport regfile (
		input  src_sel, ext_data, dst_sel, dst_we, dst_data, flags_we, flags_next,
		output src_data, flags, a, hl
	);

	// Decode side
	modport control (
		output src_sel, ext_data, dst_sel, dst_we, dst_data, flags_we, flags_next,
		input  src_data, flags, hl
	);

	// Operands only
	modport alu (
		input a, src_data, flags
	);
endinterface

`default_nettype wire

//--- cpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile import cpu_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	regfile_if.regfile rf
);
	// Indexed straight by reg_sel_t
	// Slot 6 belongs to (HL) and never holds a value
	byte_t      regs [8];
	logic [3:0] flag_q;  // z n h c

	// Data registers
	always_ff @(posedge clk) begin
		if (rf.dst_we && (rf.dst_sel != REG_MEM)) begin
			regs[rf.dst_sel] <= rf.dst_data;
		end
	end

	// Flags, only the masked bits move
	always_ff @(posedge clk) begin
		if (reset) begin
			flag_q <= 4'b0000;
		end else begin
			flag_q <= (flag_q & ~rf.flags_we) | (rf.flags_next & rf.flags_we);
		end
	end

	// Source mux
	// MEM picks the byte the control supplies
	assign rf.src_data = (rf.src_sel == REG_MEM) ? rf.ext_data : regs[rf.src_sel];

	assign rf.flags = flags_t'(flag_q);
	assign rf.a     = regs[REG_A];                  // ALU left operand
	assign rf.hl    = {regs[REG_H], regs[REG_L]};   // Indirect pointer

endmodule

`default_nettype wire

//--- cpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_alu import cpu_pkg::*; (
	regfile_if.alu  rf,
	input  alu_op_t alu_op,
	output byte_t   result,
	output flags_t  alu_flags
);
	logic       cin;   // Carry in for ADC and SBC
	logic [8:0] full;  // Result with carry or borrow
	logic [4:0] half;  // Low nibble, bit 4 is the half carry

	assign cin = ((alu_op == ALU_ADC) || (alu_op == ALU_SBC)) ? rf.flags.c : 1'b0;

	always_comb begin
		full      = '0;
		half      = '0;
		result    = '0;
		alu_flags = '0;
		case (alu_op)
			ALU_ADD, ALU_ADC: begin
				full        = {1'b0, rf.a} + {1'b0, rf.src_data} + 9'(cin);
				half        = {1'b0, rf.a[3:0]} + {1'b0, rf.src_data[3:0]} + 5'(cin);
				result      = full[7:0];
				alu_flags.h = half[4];     // Carry out of bit 3
				alu_flags.c = full[8];
			end
			ALU_SUB, ALU_SBC, ALU_CP: begin
				full        = {1'b0, rf.a} - {1'b0, rf.src_data} - 9'(cin);
				half        = {1'b0, rf.a[3:0]} - {1'b0, rf.src_data[3:0]} - 5'(cin);
				result      = full[7:0];   // CP result only feeds flags
				alu_flags.n = 1'b1;
				alu_flags.h = half[4];     // Borrow from bit 4
				alu_flags.c = full[8];     // Borrow
			end
			ALU_AND: begin
				result      = rf.a & rf.src_data;
				alu_flags.h = 1'b1;
			end
			ALU_XOR: result = rf.a ^ rf.src_data;
			ALU_OR:  result = rf.a | rf.src_data;
			ALU_INC: begin
				result      = rf.src_data + 8'd1;
				alu_flags.h = (rf.src_data[3:0] == 4'hf);  // Nibble rolls over
				alu_flags.c = rf.flags.c;                  // Carry kept
			end
			ALU_DEC: begin
				result      = rf.src_data - 8'd1;
				alu_flags.n = 1'b1;
				alu_flags.h = (rf.src_data[3:0] == 4'h0);  // Borrow into nibble
				alu_flags.c = rf.flags.c;
			end
			default: ;
		endcase
		alu_flags.z = (result == 8'h00);
	end

endmodule

`default_nettype wire

//--- cpu_bus_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_bus_sequencer import cpu_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	output addr_t   adr,
	input  byte_t   data,
	output byte_t   dout,
	output logic    ddrv,
	output logic    read,
	output logic    write,
	output mstate_t mstate,
	output byte_t   op,
	output byte_t   imml,
	output byte_t   immh,
	output addr_t   pc,
	output logic    mcycle_end,
	output byte_t   mem_data,
	input  mstate_t next_state,
	input  logic    state_load,
	input  logic    adr_load,
	input  addr_t   adr_next,
	input  logic    pc_load,
	input  addr_t   pc_next,
	input  logic    wdata_load,
	input  byte_t   wdata
);
	tcycle_t tcycle;
	byte_t   wdata_q;  // Store byte waiting for its write cycle
	logic    fetch;    // Read at PC

	assign fetch      = (mstate == IFETCH) || (mstate == IMM_LO) || (mstate == IMM_HI);
	assign mcycle_end = (tcycle == tcycle_t'(`CPU_TCYCLES - 1));

	// Cycle counter, state, PC and bus strobes
	always_ff @(posedge clk) begin
		if (reset) begin
			tcycle <= '0;
			mstate <= IFETCH;
			pc     <= `CPU_RESET_PC;
			read   <= 1'b0;
			write  <= 1'b0;
			ddrv   <= 1'b0;
		end else begin
			tcycle <= tcycle + 2'd1;
			case (tcycle)
				2'd0: ddrv <= (mstate == MEM_WRITE);  // Drive data only for stores
				2'd1: begin
					read  <= fetch || (mstate == MEM_READ);
					write <= (mstate == MEM_WRITE);
					if (fetch) begin
						pc <= pc + 16'd1;  // Step past the byte being read
					end
				end
				2'd2: write <= 1'b0;  // One clock write pulse
				2'd3: read <= 1'b0;
				default: ;
			endcase
			if (pc_load) begin
				pc <= pc_next;
			end
			if (mcycle_end) begin
				mstate <= state_load ? next_state : IFETCH;  // Default back to fetch
			end
		end
	end

	// Address, store data and the byte latches
	always_ff @(posedge clk) begin
		if ((tcycle == 2'd0) && fetch) begin
			adr <= pc;
		end
		if ((tcycle == 2'd0) && (mstate == MEM_WRITE)) begin
			dout <= wdata_q;
		end
		if (tcycle == 2'd2) begin  // Data valid while read is high
			case (mstate)
				IFETCH:   op       <= data;
				IMM_LO:   imml     <= data;
				IMM_HI:   immh     <= data;
				MEM_READ: mem_data <= data;
				default: ;
			endcase
		end
		if (adr_load) begin
			adr <= adr_next;  // HL for the next indirect cycle
		end
		if (wdata_load) begin
			wdata_q <= wdata;
		end
	end

endmodule

`default_nettype wire

//--- cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_control import cpu_pkg::*; (
	regfile_if.control rf,
	output alu_op_t    alu_op,
	input  byte_t      result,
	input  flags_t     alu_flags,
	input  mstate_t    mstate,
	input  byte_t      op,
	input  byte_t      imml,
	input  byte_t      immh,
	input  addr_t      pc,
	input  logic       mcycle_end,
	input  byte_t      mem_data,
	output mstate_t    next_state,
	output logic       state_load,
	output logic       adr_load,
	output addr_t      adr_next,
	output logic       pc_load,
	output addr_t      pc_next,
	output logic       wdata_load,
	output byte_t      wdata
);
	reg_sel_t dst_r;       // op[5:3]
	reg_sel_t src_r;       // op[2:0]
	logic     is_ld_imm;   // LD r,d8 and LD (HL),d8
	logic     is_ld_rr;    // LD r,r' block
	logic     is_alu_r;    // ALU A,r
	logic     is_alu_imm;  // ALU A,d8
	logic     is_incdec;
	logic     is_jr;
	logic     is_jp;
	logic     cond_flag;
	logic     take;        // Jump condition met
	logic     alu_wb;      // Retire an ALU result this cycle

	assign dst_r = reg_sel_t'(op[5:3]);
	assign src_r = reg_sel_t'(op[2:0]);

	assign is_ld_imm  = (op[7:6] == 2'b00) && (op[2:0] == 3'b110);
	assign is_incdec  = (op[7:6] == 2'b00) && (op[2:1] == 2'b10);
	assign is_ld_rr   = (op[7:6] == 2'b01) && (op != 8'h76);  // 76 is a NOP here
	assign is_alu_r   = (op[7:6] == 2'b10);
	assign is_alu_imm = (op[7:6] == 2'b11) && (op[2:0] == 3'b110);
	assign is_jr      = (op == 8'h18) || ((op[7:5] == 3'b001) && (op[2:0] == 3'b000));
	assign is_jp      = (op == 8'hc3) || ((op[7:5] == 3'b110) && (op[2:0] == 3'b010));

	// op[4] picks C or Z, op[3] the wanted level
	assign cond_flag = op[4] ? rf.flags.c : rf.flags.z;
	assign take      = (is_jr && !op[5]) || (is_jp && op[0]) || (cond_flag == op[3]);

	// INC/DEC work on op[5:3], everything else reads op[2:0]
	assign rf.src_sel  = (op[7:6] == 2'b00) ? dst_r : src_r;
	assign rf.ext_data = (mstate == MEM_READ) ? mem_data : imml;
	assign rf.flags_next = alu_flags;
	assign alu_op = is_incdec ? (op[0] ? ALU_DEC : ALU_INC) : alu_op_t'({1'b0, op[5:3]});

	always_comb begin
		next_state  = IFETCH;
		state_load  = 1'b0;
		adr_load    = 1'b0;
		adr_next    = rf.hl;  // Only indirect cycles load ADR
		pc_load     = 1'b0;
		pc_next     = is_jr ? pc + {{8{imml[7]}}, imml} : {immh, imml};
		wdata_load  = 1'b0;
		wdata       = rf.src_data;
		alu_wb      = 1'b0;
		rf.dst_sel  = (is_alu_r || is_alu_imm) ? REG_A : dst_r;
		rf.dst_we   = 1'b0;
		rf.dst_data = rf.src_data;
		rf.flags_we = 4'b0000;
		if (mcycle_end) begin
			case (mstate)
				IFETCH: begin
					if (is_ld_imm || is_alu_imm || is_jr || is_jp) begin
						next_state = IMM_LO;  // Operand byte follows
						state_load = 1'b1;
					end else if (((is_ld_rr || is_alu_r) && (src_r == REG_MEM)) ||
							(is_incdec && (dst_r == REG_MEM))) begin
						next_state = MEM_READ;  // Fetch (HL) first
						state_load = 1'b1;
						adr_load   = 1'b1;
					end else if (is_ld_rr && (dst_r == REG_MEM)) begin
						next_state = MEM_WRITE;  // LD (HL),r
						state_load = 1'b1;
						adr_load   = 1'b1;
						wdata_load = 1'b1;
					end else if (is_ld_rr) begin
						rf.dst_we = 1'b1;
					end else if (is_alu_r || is_incdec) begin
						alu_wb = 1'b1;
					end
				end
				IMM_LO: begin
					if (is_jp) begin
						next_state = IMM_HI;
						state_load = 1'b1;
					end else if (is_jr) begin
						next_state = JUMP;
						state_load = take;  // Not taken falls through to fetch
					end else if (is_alu_imm) begin
						alu_wb = 1'b1;
					end else if (is_ld_imm && (dst_r == REG_MEM)) begin
						next_state = MEM_WRITE;
						state_load = 1'b1;
						adr_load   = 1'b1;
						wdata_load = 1'b1;
						wdata      = imml;
					end else if (is_ld_imm) begin
						rf.dst_we   = 1'b1;
						rf.dst_data = imml;
					end
				end
				IMM_HI: begin
					next_state = JUMP;
					state_load = is_jp && take;
				end
				MEM_READ: begin
					if (is_incdec) begin
						next_state  = MEM_WRITE;  // Write back to the same HL
						state_load  = 1'b1;
						wdata_load  = 1'b1;
						wdata       = result;
						rf.flags_we = 4'b1110;
					end else if (is_alu_r) begin
						alu_wb = 1'b1;
					end else if (is_ld_rr) begin
						rf.dst_we   = 1'b1;
						rf.dst_data = mem_data;
					end
				end
				JUMP: pc_load = 1'b1;
				default: ;
			endcase
			if (alu_wb) begin
				rf.dst_data = result;
				rf.dst_we   = is_incdec || (op[5:3] != 3'd7);  // CP leaves A alone
				rf.flags_we = is_incdec ? 4'b1110 : 4'b1111;   // INC/DEC keep C
			end
		end
	end

endmodule

`default_nettype wire

//--- lr35902_core.sv
`timescale 1ns/1ps
`default_nettype none

module lr35902_core import cpu_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	output addr_t adr,
	input  byte_t data,
	output byte_t dout,
	output logic  ddrv,
	output logic  read,
	output logic  write
);
	alu_op_t alu_op;
	byte_t   result;
	flags_t  alu_flags;

	// Sequencer to control
	mstate_t mstate;
	byte_t   op;
	byte_t   imml;
	byte_t   immh;
	addr_t   pc;
	logic    mcycle_end;
	byte_t   mem_data;

	// Control to sequencer
	mstate_t next_state;
	logic    state_load;
	logic    adr_load;
	addr_t   adr_next;
	logic    pc_load;
	addr_t   pc_next;
	logic    wdata_load;
	byte_t   wdata;

	regfile_if u_rf_if ();

	cpu_regfile u_regfile (
		.clk   (clk),
		.reset (reset),
		.rf    (u_rf_if.regfile)
	);

	cpu_alu u_alu (
		.rf        (u_rf_if.alu),
		.alu_op    (alu_op),
		.result    (result),
		.alu_flags (alu_flags)
	);

	cpu_bus_sequencer u_sequencer (
		.clk        (clk),
		.reset      (reset),
		.adr        (adr),
		.data       (data),
		.dout       (dout),
		.ddrv       (ddrv),
		.read       (read),
		.write      (write),
		.mstate     (mstate),
		.op         (op),
		.imml       (imml),
		.immh       (immh),
		.pc         (pc),
		.mcycle_end (mcycle_end),
		.mem_data   (mem_data),
		.next_state (next_state),
		.state_load (state_load),
		.adr_load   (adr_load),
		.adr_next   (adr_next),
		.pc_load    (pc_load),
		.pc_next    (pc_next),
		.wdata_load (wdata_load),
		.wdata      (wdata)
	);

	cpu_control u_control (
		.rf         (u_rf_if.control),
		.alu_op     (alu_op),
		.result     (result),
		.alu_flags  (alu_flags),
		.mstate     (mstate),
		.op         (op),
		.imml       (imml),
		.immh       (immh),
		.pc         (pc),
		.mcycle_end (mcycle_end),
		.mem_data   (mem_data),
		.next_state (next_state),
		.state_load (state_load),
		.adr_load   (adr_load),
		.adr_next   (adr_next),
		.pc_load    (pc_load),
		.pc_next    (pc_next),
		.wdata_load (wdata_load),
		.wdata      (wdata)
	);

endmodule

`default_nettype wire

//--- lr35902_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module lr35902_tb import cpu_pkg::*; ();
	localparam int RESET_CYCLES = 8;
	localparam int PROG_BYTES   = 16;

	logic  clk;
	logic  reset;
	addr_t adr;
	byte_t data;
	byte_t dout;
	logic  ddrv;
	logic  read;
	logic  write;

	byte_t mem [65536];  // Flat 64 KB memory model

	// Program table, one entry per test
	string          row_name [$];
	logic [127:0]   row_prog [$];  // First byte in the top bits
	byte_t          row_init [$];  // Seeded byte at 8000
	addr_t          row_addr [$];  // Expected store address
	byte_t          row_val  [$];  // Expected store byte

	int    cycles;
	int    limit;
	int    read_len;   // Length of the current read pulse
	int    write_len;
	int    seed_dummy;
	string cur_name;

	lr35902_core u_lr35902_core (
		.clk   (clk),
		.reset (reset),
		.adr   (adr),
		.data  (data),
		.dout  (dout),
		.ddrv  (ddrv),
		.read  (read),
		.write (write)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;  // 20 ns period
	end

	// Combinational read data, no wait states
	assign data = (read === 1'b1) ? mem[adr] : 8'h00;

	// Store capture
	always @(posedge clk) begin
		if (write === 1'b1) begin
			mem[adr] = dout;
		end
	end

	// Run length guard
	always @(posedge clk) begin
		cycles = cycles + 1;
		if ((limit != 0) && (cycles >= limit)) begin
			$display("Simulation ran past %0d clocks without finishing the tests", limit);
			$display("Test failures found");
			$fatal(1, "timeout");
		end
	end

	task automatic bus_fault(input string msg);
		$display("Bus rule broken in test %s: %s", cur_name, msg);
		$display("Test failures found");
		$fatal(1, "bus rule");
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected address %h, got %h", name, exp, act);
			$display("Test failures found");
			$fatal(1, "address mismatch");
		end
	endtask

	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected byte %h, got %h", name, exp, act);
			$display("Test failures found");
			$fatal(1, "byte mismatch");
		end
	endtask

	// Bus protocol monitor, sampled mid-clock
	always @(negedge clk) begin
		if ((read === 1'b1) && (write === 1'b1)) begin
			bus_fault("read and write high together");
		end
		if ((write === 1'b1) && (ddrv !== 1'b1)) begin
			bus_fault("write high without ddrv");
		end
		if (read === 1'b1) begin
			read_len++;
		end else begin
			if ((read_len != 0) && (read_len != 2)) begin
				bus_fault("read pulse not two clocks long");
			end
			read_len = 0;
		end
		if (write === 1'b1) begin
			write_len++;
		end else begin
			if ((write_len != 0) && (write_len != 1)) begin
				bus_fault("write pulse not one clock long");
			end
			write_len = 0;
		end
	end

	task automatic add_row(input string name, input logic [127:0] prog, input byte_t init,
			input addr_t addr, input byte_t val);
		row_name.push_back(name);
		row_prog.push_back(prog);
		row_init.push_back(init);
		row_addr.push_back(addr);
		row_val.push_back(val);
	endtask

	task automatic build_table();
		// Loads and register moves, HL = 8000
		add_row("ld_reg_to_reg", 128'h26802E00_065A7877_00000000_00000000, 8'h11, 16'h8000, 8'h5A);
		add_row("ld_from_hl",    128'h26802E00_462E0170_00000000_00000000, 8'hC3, 16'h8001, 8'hC3);
		// ALU, hand worked results
		add_row("add_reg",       128'h26802E00_3E3A0627_80770000_00000000, 8'h00, 16'h8000, 8'h61);
		add_row("adc_imm_carry", 128'h26802E00_3EF00620_80CE0577_00000000, 8'h00, 16'h8000, 8'h16);
		add_row("adc_hl_carry",  128'h26802E00_3E80C680_3E218E77_00000000, 8'h0F, 16'h8000, 8'h31);
		add_row("sub_imm",       128'h26802E00_3E50D621_77000000_00000000, 8'h00, 16'h8000, 8'h2F);
		add_row("sub_hl",        128'h26802E00_3E409677_00000000_00000000, 8'h15, 16'h8000, 8'h2B);
		add_row("sbc_imm_borrow",128'h26802E00_3E10D620_DE0F7700_00000000, 8'h00, 16'h8000, 8'hE0);
		add_row("and_hl",        128'h26802E00_3EF5A677_00000000_00000000, 8'h3C, 16'h8000, 8'h34);
		add_row("and_imm",       128'h26802E00_3E0FE6A5_77000000_00000000, 8'h00, 16'h8000, 8'h05);
		add_row("xor_reg",       128'h26802E00_3EF50E0F_A9770000_00000000, 8'h00, 16'h8000, 8'hFA);
		add_row("or_hl",         128'h26802E00_3E14B677_00000000_00000000, 8'h81, 16'h8000, 8'h95);
		add_row("cp_imm",        128'h26802E00_3E42FE42_77000000_00000000, 8'h00, 16'h8000, 8'h42);
		add_row("cp_hl",         128'h26802E00_3E42BE77_00000000_00000000, 8'h50, 16'h8000, 8'h42);
		// Read modify write on (HL)
		add_row("inc_hl",        128'h26802E00_34000000_00000000_00000000, 8'h7F, 16'h8000, 8'h80);
		add_row("dec_hl",        128'h26802E00_35000000_00000000_00000000, 8'h00, 16'h8000, 8'hFF);
		add_row("inc_dec_reg",   128'h26802E00_06100578_3C3C7700_00000000, 8'h00, 16'h8000, 8'h11);
		// JP, fall-through stores A+1 at 8011, target stores A at 8022
		add_row("jp_z_taken",     128'h26802E11_3E05D605_CA0D003C_772E2277, 8'h00, 16'h8022, 8'h00);
		add_row("jp_nz_not_taken",128'h26802E11_3E05D605_C20D003C_772E2277, 8'h00, 16'h8011, 8'h01);
		add_row("jp_c_taken",     128'h26802E11_3E05D606_DA0D003C_772E2277, 8'h00, 16'h8022, 8'hFF);
		add_row("jp_nc_not_taken",128'h26802E11_3E05D606_D20D003C_772E2277, 8'h00, 16'h8011, 8'h00);
		add_row("jp_always",      128'h26802E11_3E09D602_C30D003C_772E2277, 8'h00, 16'h8022, 8'h07);
		// JR, offset 2 skips INC and store
		add_row("jr_z_not_taken", 128'h26802E11_3E05D604_28023C77_2E227700, 8'h00, 16'h8011, 8'h02);
		add_row("jr_nz_taken",    128'h26802E11_3E05D604_20023C77_2E227700, 8'h00, 16'h8022, 8'h01);
		add_row("jr_c_taken",     128'h26802E11_3E05D606_38023C77_2E227700, 8'h00, 16'h8022, 8'hFF);
		add_row("jr_c_not_taken", 128'h26802E11_3E07D606_38023C77_2E227700, 8'h00, 16'h8011, 8'h02);
		add_row("jr_nc_taken",    128'h26802E11_3E07D606_30023C77_2E227700, 8'h00, 16'h8022, 8'h01);
		add_row("jr_always",      128'h26802E11_3E05D605_18023C77_2E227700, 8'h00, 16'h8022, 8'h00);
	endtask

	task automatic run_row(input int idx);
		cur_name = row_name[idx];
		@(negedge clk);
		reset = 1'b1;
		@(negedge clk);  // Last store of the previous row has landed
		for (int i = 0; i < PROG_BYTES; i++) begin
			mem[i] = row_prog[idx][8*(PROG_BYTES-1-i) +: 8];
		end
		mem[16'h8000] = row_init[idx];
		for (int i = 0; i < RESET_CYCLES; i++) begin
			if ((read !== 1'b0) || (write !== 1'b0) || (ddrv !== 1'b0)) begin
				bus_fault("bus strobe active during reset");
			end
			if (i != RESET_CYCLES - 1) begin
				@(negedge clk);
			end
		end
		reset = 1'b0;
		// First fetch
		do @(negedge clk); while (read !== 1'b1);
		check_addr(cur_name, `CPU_RESET_PC, adr);
		// First store ends the row
		do @(negedge clk); while (write !== 1'b1);
		check_addr(cur_name, row_addr[idx], adr);
		check_byte(cur_name, row_val[idx], dout);
	endtask

	initial begin
		reset       = 1'b1;
		cycles      = 0;
		limit       = 0;
		read_len    = 0;
		write_len   = 0;
		cur_name    = "reset";
		seed_dummy  = $urandom(32'ha91f_30d2);
		for (int i = 0; i < 65536; i++) begin
			mem[i] = byte_t'($urandom);  // Background noise
		end
		build_table();
		// Worst case 16 instructions of 16 clocks, plus reset per row
		limit = row_name.size() * (16 * 16 + RESET_CYCLES + 2);
		for (int r = 0; r < row_name.size(); r++) begin
			run_row(r);
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
cpu_pkg.sv
regfile_if.sv
cpu_regfile.sv
cpu_alu.sv
cpu_bus_sequencer.sv
cpu_control.sv
lr35902_core.sv
lr35902_tb.sv

//--- Bender.yml
package:
  name: lr35902_core

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - regfile_if.sv
      - cpu_regfile.sv
      - cpu_alu.sv
      - cpu_bus_sequencer.sv
      - cpu_control.sv
      - lr35902_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - lr35902_tb.sv
